/* tb.f */
+incdir+include
rtl/cpu_pkg.sv
rtl/cpu_ramctl.sv
rtl/cpu_ctrl.sv
rtl/cpu_alu.sv
rtl/cpu_regs.sv
rtl/cpu_core.sv
bench/cpu_checker.sv
bench/cpu_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f tb.f --top-module cpu_tb -o cpu_sim \
    && ./obj_dir/cpu_sim \
    || { echo "simulation failed"; exit 1; }

/* bench/cpu_tb.sv */
/* Testbench of the 16-bit core. Word memory model with
   optional random busy stalls, directed programs for reset,
   ALU, memory, DJNZ, interrupt and clock enable behavior */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb;
    import cpu_pkg::*;

    logic        clk;
    logic        rst;
    logic        cen;
    addr_t       addr;
    word_t       din;
    word_t       dout;
    logic [1:0]  we;
    logic        busy;
    logic        irq;
    logic        irq_ack;
    dsel_t       dmp_addr;
    word_t       dmp_dout;

    word_t       mem [0:65535];
    logic        rand_busy;
    int          ack_count;
    word_t       prog [$];

    cpu_core dut0(
        .rst      ( rst      ),
        .clk      ( clk      ),
        .cen      ( cen      ),
        .addr     ( addr     ),
        .din      ( din      ),
        .dout     ( dout     ),
        .we       ( we       ),
        .busy     ( busy     ),
        .irq      ( irq      ),
        .irq_ack  ( irq_ack  ),
        .dmp_addr ( dmp_addr ),
        .dmp_dout ( dmp_dout )
    );

    always #5 clk = ~clk;

    // Memory model: combinational read, byte lane writes on completion
    assign din = mem[addr[16:1]];

    always @(posedge clk) begin
        if (cen && !busy) begin
            if (we[0]) mem[addr[16:1]][7:0] <= dout[7:0];
            if (we[1]) mem[addr[16:1]][15:8] <= dout[15:8];
        end
    end

    always @(negedge clk) begin
        busy <= rand_busy && (($urandom % 3) == 0);
    end

    always @(posedge clk) begin
        if (rst) ack_count <= 0;
        else if (cen && irq_ack) ack_count <= ack_count + 1;
    end

    function automatic word_t fill_word(int i);
        logic [31:0] x;
        x = i;
        return x[15:0] ^ {x[7:0], x[15:8]} ^ 16'h5A3C;
    endfunction

    function automatic word_t enc(opcode_e op, rsel_t rd, rsel_t rs, logic [5:0] off);
        return {op, rd, rs, off};
    endfunction

    function automatic word_t ldi(rsel_t rd, logic [8:0] v);
        return {OP_LDI, rd, v};
    endfunction

    task automatic fail_now(string line);
        $display("%s", line);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp)
            fail_now($sformatf("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp)
            fail_now($sformatf("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_flags(string name, flags_t got, flags_t exp);
        if (got !== exp)
            fail_now($sformatf("FAILED t=%0t %s: got %b expected %b", $time, name, got, exp));
    endtask

    task automatic read_dump(dsel_t idx, output word_t v);
        dmp_addr = idx;
        #0.1;
        v = dmp_dout;
    endtask

    task automatic check_reg(dsel_t idx, word_t exp);
        word_t v;
        read_dump(idx, v);
        check_word($sformatf("dump[%0d]", idx), v, exp);
    endtask

    // Fill memory, place the program at the reset PC, return the HALT address
    task automatic load_prog(output addr_t halt_a);
        for (int i = 0; i < 65536; i++) mem[i] = fill_word(i);
        for (int i = 0; i < prog.size(); i++) mem[(`CPU_RSTPC >> 1) + i] = prog[i];
        halt_a = `CPU_RSTPC + addr_t'(2 * (prog.size() - 1));
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic wait_addr(addr_t a, int limit);
        int n;
        n = 0;
        while (addr != a) begin
            if (n == limit) fail_now($sformatf("timed out waiting for bus address %h", a));
            @(negedge clk);
            n++;
        end
    endtask

    // The halted core parks its bus address on the word after HALT
    task automatic run_to_halt(addr_t halt_a);
        wait_addr(halt_a + addr_t'(2), 3000);
        repeat (4) begin
            @(negedge clk);
            check_addr("addr after HALT", addr, halt_a + addr_t'(2));
        end
    endtask

    task automatic test_reset();
        addr_t halt_a;
        prog = '{16'hB000};
        load_prog(halt_a);
        apply_reset();
        check_addr("addr", addr, `CPU_RSTPC);
        check_word("we", {14'b0, we}, 16'h0000);
        for (int i = 0; i < 8; i++) check_reg(dsel_t'(i), 16'h0000);
        check_reg(`DMP_PC, word_t'(`CPU_RSTPC));
        check_reg(`DMP_EPC, 16'h0000);
        check_reg(`DMP_FLAGS, 16'h0000);
        run_to_halt(halt_a);
    endtask

    task automatic test_alu();
        addr_t       halt_a;
        logic [31:0] r;
        logic [8:0]  a;
        logic [8:0]  b;
        word_t       aw;
        word_t       bw;
        word_t       v;
        for (int k = 0; k < 2; k++) begin
            r = $urandom;
            a = r[8:0];
            b = (k == 1) ? a : r[24:16];
            aw = {7'b0, a};
            bw = {7'b0, b};
            prog = '{ldi(3'd1, a), ldi(3'd2, b), ldi(3'd3, a), ldi(3'd4, a),
                     ldi(3'd5, a), ldi(3'd6, a), enc(OP_ADD, 3'd1, 3'd2, 6'h0),
                     enc(OP_AND, 3'd4, 3'd2, 6'h0), enc(OP_OR, 3'd5, 3'd2, 6'h0),
                     enc(OP_XOR, 3'd6, 3'd2, 6'h0), enc(OP_SUB, 3'd3, 3'd2, 6'h0),
                     16'hB000};
            load_prog(halt_a);
            apply_reset();
            run_to_halt(halt_a);
            check_reg(4'd1, aw + bw);
            check_reg(4'd2, bw);
            check_reg(4'd3, aw - bw);
            check_reg(4'd4, aw & bw);
            check_reg(4'd5, aw | bw);
            check_reg(4'd6, aw ^ bw);
            // Last op is SUB, borrow when the subtrahend is larger
            read_dump(`DMP_FLAGS, v);
            check_flags("flags", v[1:0], {aw == bw, aw < bw});
        end
    endtask

    task automatic test_memory();
        addr_t       halt_a;
        logic [31:0] r;
        word_t       vw;
        word_t       bw;
        rand_busy = 1'b1;
        r = $urandom;
        vw = {7'b0, r[8:0]};
        prog = '{ldi(3'd1, 9'h180), ldi(3'd2, r[8:0]), enc(OP_ST, 3'd1, 3'd2, 6'h0),
                 ldi(3'd3, 9'h184), ldi(3'd4, r[24:16]), enc(OP_STB, 3'd3, 3'd4, 6'h0),
                 enc(OP_LD, 3'd1, 3'd5, 6'h0), enc(OP_LD, 3'd3, 3'd6, 6'h0), 16'hB000};
        load_prog(halt_a);
        // High lane keeps the fill pattern
        bw = fill_word(32'hC2);
        bw[7:0] = r[23:16];
        apply_reset();
        run_to_halt(halt_a);
        check_word("mem[0x180]", mem[16'hC0], vw);
        check_word("mem[0x184]", mem[16'hC2], bw);
        check_reg(4'd5, vw);
        check_reg(4'd6, bw);
        rand_busy = 1'b0;
    endtask

    task automatic test_djnz();
        addr_t       halt_a;
        logic [31:0] r;
        logic [8:0]  n;
        rand_busy = 1'b1;
        r = $urandom;
        n = {5'b0, r[3:0]} + 9'd1;
        // Body at 0x106, DJNZ at 0x108 branches back by two words
        prog = '{ldi(3'd1, n), ldi(3'd2, 9'h0), ldi(3'd3, 9'h1),
                 enc(OP_ADD, 3'd2, 3'd3, 6'h0), enc(OP_DJNZ, 3'd1, 3'd0, 6'h3E),
                 16'hB000};
        load_prog(halt_a);
        apply_reset();
        run_to_halt(halt_a);
        check_reg(4'd1, 16'h0000);
        check_reg(4'd2, {7'b0, n});
        rand_busy = 1'b0;
    endtask

    task automatic test_irq();
        addr_t halt_a;
        int    n;
        prog = '{ldi(3'd1, 9'h11), ldi(3'd2, 9'h22), ldi(3'd3, 9'h33),
                 ldi(3'd4, 9'h44), 16'hB000};
        load_prog(halt_a);
        // Handler at the interrupt entry
        mem[`CPU_IRQVEC >> 1] = ldi(3'd7, 9'h155);
        mem[(`CPU_IRQVEC >> 1) + 1] = enc(OP_RETI, 3'd0, 3'd0, 6'h0);
        apply_reset();
        wait_addr(24'h000104, 100);
        irq = 1'b1;
        n = 0;
        while (!irq_ack) begin
            if (n == 50) fail_now("irq_ack never rose after irq was raised");
            @(negedge clk);
            n++;
        end
        irq = 1'b0;
        wait_addr(`CPU_IRQVEC, 20);
        run_to_halt(halt_a);
        check_reg(4'd1, 16'h0011);
        check_reg(4'd2, 16'h0022);
        check_reg(4'd3, 16'h0033);
        check_reg(4'd4, 16'h0044);
        check_reg(4'd7, 16'h0155);
        check_reg(`DMP_EPC, 16'h0104);
        check_word("irq_ack pulses", word_t'(ack_count), 16'd1);
    endtask

    task automatic test_cen();
        addr_t halt_a;
        addr_t a0;
        word_t r1;
        word_t r2;
        word_t pc0;
        prog = '{ldi(3'd1, 9'd12), ldi(3'd2, 9'h0), ldi(3'd3, 9'h1),
                 enc(OP_ADD, 3'd2, 3'd3, 6'h0), enc(OP_DJNZ, 3'd1, 3'd0, 6'h3E),
                 16'hB000};
        load_prog(halt_a);
        apply_reset();
        repeat (9) @(negedge clk);
        wait_addr(24'h000108, 100);
        cen = 1'b0;
        a0 = addr;
        read_dump(4'd1, r1);
        read_dump(4'd2, r2);
        read_dump(`DMP_PC, pc0);
        repeat (8) begin
            @(negedge clk);
            check_addr("addr", addr, a0);
            check_reg(4'd1, r1);
            check_reg(4'd2, r2);
            check_reg(`DMP_PC, pc0);
        end
        cen = 1'b1;
        run_to_halt(halt_a);
        check_reg(4'd1, 16'h0000);
        check_reg(4'd2, 16'd12);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        cen = 1'b1;
        busy = 1'b0;
        irq = 1'b0;
        dmp_addr = '0;
        rand_busy = 1'b0;
        void'($urandom(64404));
        test_reset();
        test_alu();
        test_memory();
        test_djnz();
        test_irq();
        test_cen();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* bench/cpu_checker.sv */
/* Bus and interrupt checker for the 16-bit core, bound to
   the top level: even addresses, lane enables held through
   busy stalls and a single-cycle interrupt acknowledge */
`timescale 1ns/1ps

module cpu_checker(
    input                   clk,
    input                   rst,
    input                   cen,
    input                   busy,
    input                   irq_ack,
    input  cpu_pkg::addr_t  addr,
    input  logic [1:0]      we
);

    addr_even: assert property (@(posedge clk) disable iff (rst) !addr[0])
        else $error("bus address %h is odd", addr);

    // A stalled write keeps its lanes until it completes
    we_hold: assert property (@(posedge clk) disable iff (rst)
        (cen && busy && we != 2'b00) |=> we == $past(we))
        else $error("lane enables changed during a busy stall");

    ack_pulse: assert property (@(posedge clk) disable iff (rst)
        (cen && irq_ack) |=> !irq_ack)
        else $error("irq_ack held longer than one cycle");

endmodule

bind cpu_core cpu_checker chk0(
    .clk     ( clk     ),
    .rst     ( rst     ),
    .cen     ( cen     ),
    .busy    ( busy    ),
    .irq_ack ( irq_ack ),
    .addr    ( addr    ),
    .we      ( we      )
);

/* rtl/cpu_core.sv */
/* 16-bit CPU top level. 24-bit byte bus with lane enables and
   busy wait, one level interrupt and a register dump port */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_core #(
    parameter cpu_pkg::addr_t PC_RSTVAL = `CPU_RSTPC
)(
    input                   rst,
    input                   clk,
    input                   cen,

    output cpu_pkg::addr_t  addr,
    input  cpu_pkg::word_t  din,
    output cpu_pkg::word_t  dout,
    output logic [1:0]      we,
    input                   busy,

    input                   irq,
    output logic            irq_ack,

    input  cpu_pkg::dsel_t  dmp_addr,
    output cpu_pkg::word_t  dmp_dout
);
    import cpu_pkg::*;

    // Bus controller handshake
    addr_t    pc;
    addr_t    epc;
    addr_t    mem_addr;
    logic     fetch;
    logic     mem_req;
    logic     mem_wr;
    logic     mem_byte;
    logic     mem_done;
    word_t    mem_rdata;

    // Register bank and ALU
    rsel_t    rd_sel;
    rsel_t    rs_sel;
    logic     reg_we;
    logic     wsel_mem;
    logic     flag_we;
    word_t    imm;
    alu_op_e  alu_op;
    word_t    alu_dout;
    flags_t   nx_flags;
    word_t    rd_val;
    word_t    rs_val;

    cpu_ramctl u_ramctl(
        .rst        ( rst        ),
        .clk        ( clk        ),
        .cen        ( cen        ),
        .mem_req    ( mem_req    ),
        .mem_wr     ( mem_wr     ),
        .mem_byte   ( mem_byte   ),
        .mem_addr   ( mem_addr   ),
        .pc         ( pc         ),
        .fetch      ( fetch      ),
        .wdata      ( rs_val     ),
        .addr       ( addr       ),
        .din        ( din        ),
        .dout       ( dout       ),
        .we         ( we         ),
        .busy       ( busy       ),
        .mem_done   ( mem_done   ),
        .rdata      ( mem_rdata  )
    );

    cpu_ctrl u_ctrl(
        .rst        ( rst        ),
        .clk        ( clk        ),
        .cen        ( cen        ),
        .pc_rstval  ( PC_RSTVAL  ),
        .irq        ( irq        ),
        .irq_ack    ( irq_ack    ),
        .rdata      ( mem_rdata  ),
        .mem_done   ( mem_done   ),
        .rd_val     ( rd_val     ),
        .pc         ( pc         ),
        .epc        ( epc        ),
        .fetch      ( fetch      ),
        .mem_req    ( mem_req    ),
        .mem_wr     ( mem_wr     ),
        .mem_byte   ( mem_byte   ),
        .mem_addr   ( mem_addr   ),
        .rd_sel     ( rd_sel     ),
        .rs_sel     ( rs_sel     ),
        .reg_we     ( reg_we     ),
        .wsel_mem   ( wsel_mem   ),
        .imm        ( imm        ),
        .alu_op     ( alu_op     ),
        .flag_we    ( flag_we    )
    );

    cpu_alu u_alu(
        .op         ( alu_op     ),
        .a          ( rd_val     ),
        .b          ( rs_val     ),
        .imm        ( imm        ),
        .dout       ( alu_dout   ),
        .nx_flags   ( nx_flags   )
    );

    cpu_regs u_regs(
        .rst        ( rst        ),
        .clk        ( clk        ),
        .cen        ( cen        ),
        .rd_sel     ( rd_sel     ),
        .rs_sel     ( rs_sel     ),
        .reg_we     ( reg_we     ),
        .wsel_mem   ( wsel_mem   ),
        .alu_dout   ( alu_dout   ),
        .mem_rdata  ( mem_rdata  ),
        .flag_we    ( flag_we    ),
        .nx_flags   ( nx_flags   ),
        .pc         ( pc         ),
        .epc        ( epc        ),
        .rd_val     ( rd_val     ),
        .rs_val     ( rs_val     ),
        .flags      (            ),
        .dmp_addr   ( dmp_addr   ),
        .dmp_dout   ( dmp_dout   )
    );

endmodule

/* rtl/cpu_regs.sv */
/* Register bank. Eight general registers, the Z/C flags and
   the combinational register dump port */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_regs(
    input                   rst,
    input                   clk,
    input                   cen,

    input  cpu_pkg::rsel_t  rd_sel,
    input  cpu_pkg::rsel_t  rs_sel,
    input                   reg_we,
    input                   wsel_mem,
    input  cpu_pkg::word_t  alu_dout,
    input  cpu_pkg::word_t  mem_rdata,
    input                   flag_we,
    input  cpu_pkg::flags_t nx_flags,
    input  cpu_pkg::addr_t  pc,
    input  cpu_pkg::addr_t  epc,

    output cpu_pkg::word_t  rd_val,
    output cpu_pkg::word_t  rs_val,
    output cpu_pkg::flags_t flags,

    // Register dump
    input  cpu_pkg::dsel_t  dmp_addr,
    output cpu_pkg::word_t  dmp_dout
);
    import cpu_pkg::*;

    word_t regs [0:7];
    word_t wr_data;

    assign wr_data = wsel_mem ? mem_rdata : alu_dout;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
            flags <= '0;
        end else if (cen) begin
            if (reg_we) regs[rd_sel] <= wr_data;
            if (flag_we) flags <= nx_flags;
        end
    end

    assign rd_val = regs[rd_sel];
    assign rs_val = regs[rs_sel];

    // Indexes past DMP_FLAGS read as zero
    always_comb begin
        case (dmp_addr)
            `DMP_PC:    dmp_dout = pc[`CPU_DW-1:0];
            `DMP_EPC:   dmp_dout = epc[`CPU_DW-1:0];
            `DMP_FLAGS: dmp_dout = {{(`CPU_DW-2){1'b0}}, flags};
            default:    dmp_dout = dmp_addr[3] ? '0 : regs[dmp_addr[2:0]];
        endcase
    end

endmodule

/* rtl/cpu_alu.sv */
/* ALU. Combinational add, subtract, logic, decrement and
   immediate pass, with the next Z and C flags */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_alu(
    input  cpu_pkg::alu_op_e op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::word_t   imm,
    output cpu_pkg::word_t   dout,
    output cpu_pkg::flags_t  nx_flags
);
    import cpu_pkg::*;

    logic [`CPU_DW:0] sum;
    logic [`CPU_DW:0] diff;
    word_t            decr;
    logic             carry;

    assign sum  = {1'b0, a} + {1'b0, b};
    // MSB is the borrow
    assign diff = {1'b0, a} - {1'b0, b};
    assign decr = a - word_t'(1);

    always_comb begin
        case (op)
            ALU_ADD: dout = sum[`CPU_DW-1:0];
            ALU_SUB: dout = diff[`CPU_DW-1:0];
            ALU_AND: dout = a & b;
            ALU_OR:  dout = a | b;
            ALU_XOR: dout = a ^ b;
            ALU_DEC: dout = decr;
            default: dout = imm;
        endcase
    end

    // Carry only for the arithmetic ops
    always_comb begin
        case (op)
            ALU_ADD: carry = sum[`CPU_DW];
            ALU_SUB: carry = diff[`CPU_DW];
            default: carry = 1'b0;
        endcase
    end

    assign nx_flags = {dout == '0, carry};

endmodule

/* rtl/cpu_ctrl.sv */
/* Control unit. Holds the instruction register and the PC,
   runs the fetch/execute state machine, decodes the opcodes
   and handles interrupt entry, EPC and RETI */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_ctrl(
    input                    rst,
    input                    clk,
    input                    cen,
    input  cpu_pkg::addr_t   pc_rstval,

    input                    irq,
    output logic             irq_ack,

    input  cpu_pkg::word_t   rdata,
    input                    mem_done,
    input  cpu_pkg::word_t   rd_val,

    output cpu_pkg::addr_t   pc,
    output cpu_pkg::addr_t   epc,
    output logic             fetch,
    output logic             mem_req,
    output logic             mem_wr,
    output logic             mem_byte,
    output cpu_pkg::addr_t   mem_addr,

    output cpu_pkg::rsel_t   rd_sel,
    output cpu_pkg::rsel_t   rs_sel,
    output logic             reg_we,
    output logic             wsel_mem,
    output cpu_pkg::word_t   imm,
    output cpu_pkg::alu_op_e alu_op,
    output logic             flag_we
);
    import cpu_pkg::*;

    ctrl_state_e state;
    word_t       ir;
    logic        ie;
    opcode_e     op;
    logic        in_exec;
    logic        is_alu;
    logic        is_mem;
    logic        djnz_taken;
    addr_t       br_off;

    assign op      = opcode_e'(ir[15:12]);
    assign in_exec = state == S_EXEC;
    assign is_alu  = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
    assign is_mem  = op inside {OP_LD, OP_ST, OP_STB};

    always_comb begin
        case (op)
            OP_ADD:  alu_op = ALU_ADD;
            OP_SUB:  alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            OP_XOR:  alu_op = ALU_XOR;
            OP_DJNZ: alu_op = ALU_DEC;
            default: alu_op = ALU_PASS;
        endcase
    end

    // Bus requests follow the state
    assign fetch    = state == S_FETCH;
    assign mem_req  = state == S_MEM;
    assign mem_wr   = op inside {OP_ST, OP_STB};
    assign mem_byte = op == OP_STB;
    assign irq_ack  = state == S_IRQ;

    // LD writes the rs field register once the pointer is latched
    assign rd_sel   = mem_req ? ir[8:6] : ir[11:9];
    assign rs_sel   = ir[8:6];
    assign wsel_mem = mem_req;
    assign reg_we   = (in_exec && (is_alu || op == OP_LDI || op == OP_DJNZ)) ||
                      (mem_req && mem_done && op == OP_LD);
    assign flag_we  = in_exec & is_alu;
    assign imm      = {{(`CPU_DW-9){1'b0}}, ir[8:0]};

    // Counter reaches zero when it held 1 before the decrement
    assign djnz_taken = rd_val != word_t'(1);
    assign br_off     = {{(`CPU_AW-7){ir[5]}}, ir[5:0], 1'b0};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_FETCH;
            pc    <= pc_rstval;
            epc   <= '0;
            ie    <= 1'b1;
            ir    <= '0;
        end else if (cen) begin
            case (state)
                S_FETCH: begin
                    if (mem_done) begin
                        if (irq && ie) begin
                            // Fetched word dropped, it runs after RETI
                            epc   <= pc;
                            pc    <= `CPU_IRQVEC;
                            ie    <= 1'b0;
                            state <= S_IRQ;
                        end else begin
                            ir    <= rdata;
                            pc    <= pc + addr_t'(2);
                            state <= S_EXEC;
                        end
                    end
                end
                S_EXEC: begin
                    state <= is_mem ? S_MEM : S_FETCH;
                    case (op)
                        OP_DJNZ: if (djnz_taken) pc <= pc + br_off;
                        OP_RETI: begin
                            pc <= epc;
                            ie <= 1'b1;
                        end
                        OP_HALT: state <= S_HALT;
                        default: ;
                    endcase
                end
                S_MEM:   if (mem_done) state <= S_FETCH;
                S_IRQ:   state <= S_FETCH;
                // S_HALT only leaves on reset
                default: state <= S_HALT;
            endcase
        end
    end

    // Pointer from the rd field, forced even
    always_ff @(posedge clk) begin
        if (cen && in_exec && is_mem) begin
            mem_addr <= {{(`CPU_AW-`CPU_DW){1'b0}}, rd_val[`CPU_DW-1:1], 1'b0};
        end
    end

endmodule

/* rtl/cpu_ramctl.sv */
/* Bus controller. Picks the fetch or data address, keeps
   address, write data and lane enables steady through busy
   stalls and captures the read word on completion */
`timescale 1ns/1ps

module cpu_ramctl(
    input                   rst,
    input                   clk,
    input                   cen,

    // Requests from the control unit
    input                   mem_req,
    input                   mem_wr,
    input                   mem_byte,
    input  cpu_pkg::addr_t  mem_addr,
    input  cpu_pkg::addr_t  pc,
    input                   fetch,
    input  cpu_pkg::word_t  wdata,

    // External bus
    output cpu_pkg::addr_t  addr,
    input  cpu_pkg::word_t  din,
    output cpu_pkg::word_t  dout,
    output logic [1:0]      we,
    input                   busy,

    output logic            mem_done,
    output cpu_pkg::word_t  rdata
);
    import cpu_pkg::*;

    logic        access;
    logic        held;
    addr_t       addr_nx;
    addr_t       addr_q;
    word_t       dout_nx;
    word_t       dout_q;
    logic [1:0]  we_nx;
    logic [1:0]  we_q;
    word_t       rdata_q;

    assign access   = fetch | mem_req;
    assign mem_done = access & ~busy;

    // What the bus shows when a new access starts
    assign addr_nx = mem_req ? mem_addr : pc;
    assign dout_nx = mem_byte ? word_t'(wdata[7:0]) : wdata;
    assign we_nx   = !(mem_req && mem_wr) ? 2'b00 :
                     mem_byte             ? 2'b01 : 2'b11;

    // held marks the cycles after the first one of a stalled access
    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
            we_q <= 2'b00;
        end else if (cen) begin
            held <= access & busy;
            if (!held) we_q <= we_nx;
        end
    end

    always_ff @(posedge clk) begin
        if (cen && !held) begin
            addr_q <= addr_nx;
            dout_q <= dout_nx;
        end
    end

    assign addr = held ? addr_q : addr_nx;
    assign dout = held ? dout_q : dout_nx;
    assign we   = held ? we_q   : we_nx;

    // Read word passes through in the completing cycle, then is kept
    always_ff @(posedge clk) begin
        if (cen && mem_done) rdata_q <= din;
    end

    assign rdata = mem_done ? din : rdata_q;

endmodule

/* rtl/cpu_pkg.sv */
/* Types of the 16-bit core: bus and register widths, the
   instruction opcodes, ALU operations and control states */
`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`CPU_AW-1:0] addr_t;
    typedef logic [`CPU_DW-1:0] word_t;
    typedef logic [2:0]         rsel_t;
    typedef logic [3:0]         dsel_t;
    // Z in bit 1, C in bit 0
    typedef logic [1:0]         flags_t;

    // Memory ops use rd as the pointer and rs as the data register
    typedef enum logic [3:0] {
        OP_LDI  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_LD   = 4'd6,
        OP_ST   = 4'd7,
        OP_STB  = 4'd8,
        OP_DJNZ = 4'd9,
        OP_RETI = 4'd10,
        OP_HALT = 4'd11
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_DEC
    } alu_op_e;

    typedef enum logic [2:0] {
        S_FETCH, S_EXEC, S_MEM, S_IRQ, S_HALT
    } ctrl_state_e;

endpackage

/* include/cpu_defs.svh */
/* Shared constants of the 16-bit core: bus widths, the default
   reset PC, the interrupt entry point and the register dump map */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Bus widths
`define CPU_AW 24
`define CPU_DW 16

// Default reset PC, overridable through PC_RSTVAL
`define CPU_RSTPC  24'h000100
// Interrupt entry
`define CPU_IRQVEC 24'h000040

// Dump indexes after the eight general registers
`define DMP_PC    4'd8
`define DMP_EPC   4'd9
`define DMP_FLAGS 4'd10

`endif
